// ==== rtl/fft2d_pkg.sv ====
`default_nettype none

package fft2d_pkg;

  // frame geometry
  localparam int N_PT      = 4;            // points per lane, also frame side
  localparam int FRAME_LEN = N_PT * N_PT;  // samples per frame

  // component widths
  // each 4-point pass grows the magnitude by at most a factor of 4
  localparam int IN_W  = 12;               // stream input
  localparam int ROW_W = IN_W + 2;         // after row pass
  localparam int OUT_W = ROW_W + 2;        // after column pass

  // complex samples, im in the upper half, re in the lower half
  typedef struct packed {
    logic signed [IN_W-1:0] im;            // imaginary part
    logic signed [IN_W-1:0] re;            // real part
  } cpx_in_t;

  typedef struct packed {
    logic signed [ROW_W-1:0] im;           // imaginary part
    logic signed [ROW_W-1:0] re;           // real part
  } cpx_row_t;

  typedef struct packed {
    logic signed [OUT_W-1:0] im;           // imaginary part
    logic signed [OUT_W-1:0] re;           // real part
  } cpx_out_t;

endpackage

`default_nettype wire

// ==== rtl/dft4_lane.sv ====
`default_nettype none

module dft4_lane #(
  parameter type in_t  = fft2d_pkg::cpx_in_t,   // lane input sample
  parameter type out_t = fft2d_pkg::cpx_row_t   // lane output sample, 2 bits wider
) (
  input  wire logic                        clk,
  input  wire logic                        rst_n_i,
  input  wire logic                        valid_i,
  output      logic                        ready_o,
  input  wire in_t  [fft2d_pkg::N_PT-1:0]  pts_i,
  output      logic                        valid_o,
  input  wire logic                        ready_i,
  output      out_t [fft2d_pkg::N_PT-1:0]  pts_o
);

  out_t                        ext [fft2d_pkg::N_PT];  // inputs sign-extended
  out_t                        s_ac, d_ac;             // a+c, a-c
  out_t                        s_bd, d_bd;             // b+d, b-d
  out_t [fft2d_pkg::N_PT-1:0]  xf;                     // transform result
  out_t [fft2d_pkg::N_PT-1:0]  pts_q;                  // result register
  logic                        valid_q;

  // radix-4 butterfly, twiddles are only +-1 and +-j
  always_comb
  begin
    for (int i = 0; i < fft2d_pkg::N_PT; i++)
    begin
      ext[i].re = pts_i[i].re;                 // signed fields, sign extension
      ext[i].im = pts_i[i].im;
    end
    s_ac.re = ext[0].re + ext[2].re;
    s_ac.im = ext[0].im + ext[2].im;
    d_ac.re = ext[0].re - ext[2].re;
    d_ac.im = ext[0].im - ext[2].im;
    s_bd.re = ext[1].re + ext[3].re;
    s_bd.im = ext[1].im + ext[3].im;
    d_bd.re = ext[1].re - ext[3].re;
    d_bd.im = ext[1].im - ext[3].im;
    xf[0].re = s_ac.re + s_bd.re;              // X0 = a+b+c+d
    xf[0].im = s_ac.im + s_bd.im;
    xf[2].re = s_ac.re - s_bd.re;              // X2 = a-b+c-d
    xf[2].im = s_ac.im - s_bd.im;
    xf[1].re = d_ac.re + d_bd.im;              // -j(b-d) swaps re/im, negates new im
    xf[1].im = d_ac.im - d_bd.re;
    xf[3].re = d_ac.re - d_bd.im;              // +j(b-d) negates new re
    xf[3].im = d_ac.im + d_bd.re;
  end

  assign ready_o = !valid_q || ready_i;        // empty, or current result leaves now

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
      valid_q <= 1'b0;
    else if (ready_o)
      valid_q <= valid_i;
    if (valid_i && ready_o)
      pts_q <= xf;                             // load on transfer only
  end

  assign valid_o = valid_q;
  assign pts_o   = pts_q;

  // a stalled result must not change under the consumer
  a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
    valid_o && !ready_i |=> $stable(pts_o))
    else $error("dft4_lane: pts_o changed while stalled");

endmodule

`default_nettype wire

// ==== rtl/frame_loader.sv ====
`default_nettype none

module frame_loader (
  input  wire logic  clk,
  input  wire logic  rst_n_i,
  input  wire logic  in_valid_i,
  output      logic  in_ready_o,
  input  wire fft2d_pkg::cpx_in_t  in_sample_i,
  output      logic  frame_valid_o,
  input  wire logic  frame_ready_i,
  output      fft2d_pkg::cpx_in_t [fft2d_pkg::N_PT-1:0][fft2d_pkg::N_PT-1:0]  rows_o
);

  fft2d_pkg::cpx_in_t [fft2d_pkg::N_PT-1:0][fft2d_pkg::N_PT-1:0]  frame_q;  // [row][col]

  logic [$clog2(fft2d_pkg::FRAME_LEN)-1:0]  cnt_q;     // row-major sample index
  logic [$clog2(fft2d_pkg::N_PT)-1:0]       wr_row;
  logic [$clog2(fft2d_pkg::N_PT)-1:0]       wr_col;
  logic                                     full_q;    // frame complete, offered
  logic                                     in_fire;
  logic                                     last_in;

  assign {wr_row, wr_col} = cnt_q;             // upper bits row, lower bits column
  assign in_fire = in_valid_i && in_ready_o;
  assign last_in = cnt_q == $bits(cnt_q)'(fft2d_pkg::FRAME_LEN - 1);

  // control: fill, then hold until the row lanes take the frame
  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      cnt_q  <= '0;
      full_q <= 1'b0;
    end
    else
    begin
      if (in_fire)
      begin
        cnt_q <= cnt_q + 1'b1;                 // wraps to 0 after sample 16
        if (last_in)
          full_q <= 1'b1;
      end
      if (frame_valid_o && frame_ready_i)
        full_q <= 1'b0;                        // frame handed over
    end
  end

  // sample storage
  always_ff @(posedge clk)
  begin
    if (in_fire)
      frame_q[wr_row][wr_col] <= in_sample_i;
  end

  assign in_ready_o    = !full_q;              // stop input while frame waits
  assign frame_valid_o = full_q;
  assign rows_o        = frame_q;              // row r feeds row lane r

  // the offered frame must never be overwritten by new input
  a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n_i)
    frame_valid_o |-> !in_ready_o)
    else $error("frame_loader: input open while frame offered");

endmodule

`default_nettype wire

// ==== rtl/frame_unloader.sv ====
`default_nettype none

module frame_unloader (
  input  wire logic  clk,
  input  wire logic  rst_n_i,
  input  wire logic  frame_valid_i,
  output      logic  frame_ready_o,
  input  wire fft2d_pkg::cpx_out_t [fft2d_pkg::N_PT-1:0][fft2d_pkg::N_PT-1:0]  cols_i,
  output      logic  out_valid_o,
  input  wire logic  out_ready_i,
  output      fft2d_pkg::cpx_out_t  out_sample_o,
  output      logic  out_last_o
);

  fft2d_pkg::cpx_out_t [fft2d_pkg::N_PT-1:0][fft2d_pkg::N_PT-1:0]  cols_q;  // [col][row]

  logic [$clog2(fft2d_pkg::FRAME_LEN)-1:0]  cnt_q;     // row-major output index
  logic [$clog2(fft2d_pkg::N_PT)-1:0]       rd_row;
  logic [$clog2(fft2d_pkg::N_PT)-1:0]       rd_col;
  logic                                     busy_q;    // frame held, streaming
  logic                                     out_fire;

  assign {rd_row, rd_col} = cnt_q;
  assign out_fire = out_valid_o && out_ready_i;

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      cnt_q  <= '0;
      busy_q <= 1'b0;
    end
    else if (frame_valid_i && frame_ready_o)
      busy_q <= 1'b1;                          // counter already back at 0
    else if (out_fire)
    begin
      cnt_q <= cnt_q + 1'b1;
      if (out_last_o)
        busy_q <= 1'b0;                        // last sample gone, free again
    end
  end

  // result capture
  always_ff @(posedge clk)
  begin
    if (frame_valid_i && frame_ready_o)
      cols_q <= cols_i;
  end

  assign frame_ready_o = !busy_q;              // one frame at a time
  assign out_valid_o   = busy_q;
  // column lane v point u is X[u][v], read back row-major
  assign out_sample_o  = cols_q[rd_col][rd_row];
  assign out_last_o    = busy_q && (cnt_q == $bits(cnt_q)'(fft2d_pkg::FRAME_LEN - 1));

  a_last_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
    out_last_o |-> out_valid_o)
    else $error("frame_unloader: last without valid");

endmodule

`default_nettype wire

// ==== rtl/fft2d_top.sv ====
`default_nettype none

module fft2d_top (
  input  wire logic                 clk,
  input  wire logic                 rst_n_i,
  input  wire logic                 in_valid_i,
  output      logic                 in_ready_o,
  input  wire fft2d_pkg::cpx_in_t   in_sample_i,
  output      logic                 out_valid_o,
  input  wire logic                 out_ready_i,
  output      fft2d_pkg::cpx_out_t  out_sample_o,
  output      logic                 out_last_o
);

  fft2d_pkg::cpx_in_t  [fft2d_pkg::N_PT-1:0][fft2d_pkg::N_PT-1:0]  rows;      // [row][col]
  fft2d_pkg::cpx_row_t [fft2d_pkg::N_PT-1:0][fft2d_pkg::N_PT-1:0]  row_pts;   // [lane][pt]
  fft2d_pkg::cpx_row_t [fft2d_pkg::N_PT-1:0][fft2d_pkg::N_PT-1:0]  col_pts;   // [lane][pt]
  fft2d_pkg::cpx_out_t [fft2d_pkg::N_PT-1:0][fft2d_pkg::N_PT-1:0]  cols;      // [lane][pt]

  logic                        frame_valid;
  logic [fft2d_pkg::N_PT-1:0]  row_valid, row_ready;   // lanes run in lock step
  logic [fft2d_pkg::N_PT-1:0]  col_valid, col_ready;   // lane 0 speaks for all
  logic                        unl_ready;

  frame_loader u_frame_loader (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .in_valid_i    (in_valid_i),
    .in_ready_o    (in_ready_o),
    .in_sample_i   (in_sample_i),
    .frame_valid_o (frame_valid),
    .frame_ready_i (row_ready[0]),
    .rows_o        (rows)
  );

  // row pass
  for (genvar r = 0; r < fft2d_pkg::N_PT; r++)
  begin : g_row
    dft4_lane #(
      .in_t  (fft2d_pkg::cpx_in_t),
      .out_t (fft2d_pkg::cpx_row_t)
    ) u_row_lane (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .valid_i (frame_valid),
      .ready_o (row_ready[r]),
      .pts_i   (rows[r]),
      .valid_o (row_valid[r]),
      .ready_i (col_ready[0]),
      .pts_o   (row_pts[r])
    );
  end

  // corner turn: point k of row lane r becomes point r of column lane k
  for (genvar k = 0; k < fft2d_pkg::N_PT; k++)
  begin : g_col
    for (genvar r = 0; r < fft2d_pkg::N_PT; r++)
    begin : g_turn
      assign col_pts[k][r] = row_pts[r][k];
    end

    dft4_lane #(
      .in_t  (fft2d_pkg::cpx_row_t),
      .out_t (fft2d_pkg::cpx_out_t)
    ) u_col_lane (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .valid_i (row_valid[0]),
      .ready_o (col_ready[k]),
      .pts_i   (col_pts[k]),
      .valid_o (col_valid[k]),
      .ready_i (unl_ready),
      .pts_o   (cols[k])
    );
  end

  frame_unloader u_frame_unloader (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .frame_valid_i (col_valid[0]),
    .frame_ready_o (unl_ready),
    .cols_i        (cols),
    .out_valid_o   (out_valid_o),
    .out_ready_i   (out_ready_i),
    .out_sample_o  (out_sample_o),
    .out_last_o    (out_last_o)
  );

endmodule

`default_nettype wire

// ==== tb/tb_fft2d.sv ====
`default_nettype none

module tb_fft2d;

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] SEED      = 32'hb642;
  localparam logic [31:0] LFSR_POLY = 32'h8020_0003;  // x^32+x^22+x^2+x+1
  localparam int N_RAND    = 20;                      // back-to-back frames
  localparam int N_STALL   = 10;                      // frames with gaps and stalls
  localparam int N_FRAMES  = 2 + N_RAND + N_STALL + 2;
  localparam int TIMEOUT   = 40 * N_FRAMES + 200;     // cycles
  localparam int LEN       = fft2d_pkg::FRAME_LEN;
  localparam int S_MAX     = (1 << (fft2d_pkg::IN_W - 1)) - 1;
  localparam int S_MIN     = -(1 << (fft2d_pkg::IN_W - 1));

  logic                 clk;
  logic                 rst_n_i;
  logic                 in_valid_i;
  logic                 in_ready_o;
  fft2d_pkg::cpx_in_t   in_sample_i;
  logic                 out_valid_o;
  logic                 out_ready_i;
  fft2d_pkg::cpx_out_t  out_sample_o;
  logic                 out_last_o;

  int           fr_re [LEN];                // current frame in row-major order
  int           fr_im [LEN];
  int           exp_re_q [$];               // expected results in output order
  int           exp_im_q [$];
  int           errors;
  int           checks;
  int           err_mark;                   // errors at start of test
  int           out_cnt;                    // output transfers seen
  int           cycles;
  logic [31:0]  stim_lfsr;                  // samples and input gaps
  logic [31:0]  bp_lfsr;                    // output back-pressure
  bit           bp_en;

  fft2d_top u_fft2d_top (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .in_sample_i  (in_sample_i),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .out_sample_o (out_sample_o),
    .out_last_o   (out_last_o)
  );

  always #10 clk = ~clk;                    // 20 ns period

  // galois step shifts right and folds the taps back in
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ LFSR_POLY;
    else
      return s >> 1;
  endfunction

  // one lfsr step per bit taken
  task automatic take_bits(inout logic [31:0] st, input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v  = {v[30:0], st[0]};
      st = lfsr_next(st);
    end
  endtask

  task automatic check_val(input int got, input int exp, input string what);
    checks++;
    if (got != exp)
    begin
      $display("Mismatch at %0t ns: %s, got %0d expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  // X[u][v] = sum x[m][n] * (-j)^(um+vn) in exact integers
  function automatic void dft2d_ref();
    int acc_re, acc_im, a, b, k;
    for (int u = 0; u < fft2d_pkg::N_PT; u++)
    begin
      for (int v = 0; v < fft2d_pkg::N_PT; v++)
      begin
        acc_re = 0;
        acc_im = 0;
        for (int m = 0; m < fft2d_pkg::N_PT; m++)
        begin
          for (int n = 0; n < fft2d_pkg::N_PT; n++)
          begin
            a = fr_re[m * fft2d_pkg::N_PT + n];
            b = fr_im[m * fft2d_pkg::N_PT + n];
            k = (u * m + v * n) % 4;
            case (k)
              0:
              begin
                acc_re += a;
                acc_im += b;
              end
              1:
              begin
                acc_re += b;                // times -j
                acc_im -= a;
              end
              2:
              begin
                acc_re -= a;                // times -1
                acc_im -= b;
              end
              default:
              begin
                acc_re -= b;                // times +j
                acc_im += a;
              end
            endcase
          end
        end
        exp_re_q.push_back(acc_re);
        exp_im_q.push_back(acc_im);
      end
    end
  endfunction

  // hold valid until ready was seen before an edge
  task automatic wait_in_transfer();
    logic took;
    do
    begin
      @(negedge clk);
      took = in_ready_o;                    // stable mid-cycle
      @(posedge clk);
      #1;
    end
    while (!took);
  endtask

  task automatic send_frame(input bit gaps);
    logic [31:0] g;
    dft2d_ref();
    for (int i = 0; i < LEN; i++)
    begin
      if (gaps)
      begin
        take_bits(stim_lfsr, 1, g);
        if (g[0])
        begin
          in_valid_i = 1'b0;                // one idle cycle
          @(posedge clk);
          #1;
        end
      end
      in_valid_i     = 1'b1;
      in_sample_i.re = fr_re[i][fft2d_pkg::IN_W-1:0];
      in_sample_i.im = fr_im[i][fft2d_pkg::IN_W-1:0];
      wait_in_transfer();
    end
    in_valid_i = 1'b0;
  endtask

  task automatic fill_random();
    logic [31:0] v;
    for (int i = 0; i < LEN; i++)
    begin
      take_bits(stim_lfsr, fft2d_pkg::IN_W, v);
      fr_re[i] = int'($signed(v[fft2d_pkg::IN_W-1:0]));
      take_bits(stim_lfsr, fft2d_pkg::IN_W, v);
      fr_im[i] = int'($signed(v[fft2d_pkg::IN_W-1:0]));
    end
  endtask

  task automatic fill_const(input int re, input int im);
    for (int i = 0; i < LEN; i++)
    begin
      fr_re[i] = re;
      fr_im[i] = im;
    end
  endtask

  // drain the pipeline and report this test
  task automatic end_test(input string name);
    while (exp_re_q.size() != 0)
      @(posedge clk);
    repeat (3) @(posedge clk);
    #1;
    if (errors == err_mark)
      $display("test %s: ok", name);
    else
      $display("test %s: %0d errors", name, errors - err_mark);
    err_mark = errors;
  endtask

  // scoreboard sees each transfer half a cycle before its edge
  always @(negedge clk)
  begin
    if (rst_n_i && out_valid_o && out_ready_i)
    begin
      if (exp_re_q.size() == 0)
      begin
        $display("output sample at %0t ns arrived with no frame pending", $time);
        errors++;
      end
      else
      begin
        check_val(int'(out_sample_o.re), exp_re_q.pop_front(),
                  $sformatf("frame %0d sample %0d re", out_cnt / LEN, out_cnt % LEN));
        check_val(int'(out_sample_o.im), exp_im_q.pop_front(),
                  $sformatf("frame %0d sample %0d im", out_cnt / LEN, out_cnt % LEN));
        check_val(int'(out_last_o), int'(out_cnt % LEN == LEN - 1),
                  $sformatf("frame %0d sample %0d last", out_cnt / LEN, out_cnt % LEN));
        out_cnt++;
      end
    end
  end

  // random stalls on the output side
  always @(posedge clk)
  begin
    logic [31:0] r;
    #1;
    if (bp_en)
    begin
      take_bits(bp_lfsr, 2, r);
      out_ready_i = (r[1:0] != 2'b00);      // ready about 3 cycles in 4
    end
    else
      out_ready_i = 1'b1;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= TIMEOUT)
    begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT);
      $display("Testbench failed");
      $finish;
    end
  end

  initial
  begin
    clk         = 1'b0;
    rst_n_i     = 1'b0;
    in_valid_i  = 1'b0;
    in_sample_i = '0;
    out_ready_i = 1'b1;
    stim_lfsr   = SEED;
    bp_lfsr     = lfsr_next(SEED);          // offset from the stimulus stream
    bp_en       = 1'b0;
    errors      = 0;
    checks      = 0;
    err_mark    = 0;
    out_cnt     = 0;
    cycles      = 0;
    repeat (5) @(posedge clk);
    #1;
    rst_n_i = 1'b1;

    @(negedge clk);
    check_val(int'(out_valid_o), 0, "out_valid_o after reset");
    check_val(int'(out_last_o), 0, "out_last_o after reset");
    check_val(int'(in_ready_o), 1, "in_ready_o after reset");
    @(posedge clk);
    #1;
    end_test("reset");

    fill_const(0, 0);
    fr_re[0] = 1000;                        // impulse at row 0, column 0
    fr_im[0] = -300;
    send_frame(1'b0);
    end_test("impulse");

    fill_const(100, -77);
    send_frame(1'b0);
    end_test("constant");

    for (int f = 0; f < N_RAND; f++)
    begin
      fill_random();
      send_frame(1'b0);
    end
    end_test("random back-to-back");

    bp_en = 1'b1;
    for (int f = 0; f < N_STALL; f++)
    begin
      fill_random();
      send_frame(1'b1);
    end
    end_test("random with stalls");
    bp_en = 1'b0;

    fill_const(S_MIN, S_MIN);               // largest possible dc term
    send_frame(1'b0);
    for (int i = 0; i < LEN; i++)
    begin
      fr_re[i] = ((i / fft2d_pkg::N_PT + i % fft2d_pkg::N_PT) % 2 == 0) ? S_MAX : S_MIN;
      fr_im[i] = ((i / fft2d_pkg::N_PT + i % fft2d_pkg::N_PT) % 2 == 0) ? S_MIN : S_MAX;
    end
    send_frame(1'b0);
    end_test("extremes");

    $display("checks %0d, errors %0d, outputs %0d", checks, errors, out_cnt);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
rtl/fft2d_pkg.sv
rtl/dft4_lane.sv
rtl/frame_loader.sv
rtl/frame_unloader.sv
rtl/fft2d_top.sv
tb/tb_fft2d.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_fft2d
FILELIST  = all.f
OBJ_DIR   = obj_dir
PASS_MSG  = Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
